/* verilog/adc_cmd_pkg.sv */
package adc_cmd_pkg;

   typedef logic [4:0]  rom_addr_t;    // Byte table address
   typedef logic [7:0]  init_byte_t;   // One serial byte either way
   typedef logic [23:0] rd_word_t;     // Three bytes read back

   // CS5523 read commands
   localparam init_byte_t CMD_READ_CFG = 8'h0B;   // Read configuration register
   localparam init_byte_t CMD_READ_CSR = 8'h0D;   // Read channel-setup registers

   localparam int SCRIPT_LEN = 75;   // Bytes in the power-up script

   // Table address of every script byte in send order
   localparam rom_addr_t SCRIPT_ADDR [SCRIPT_LEN] = '{
      5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1,    // Port sync fill
      5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2,    // Then the 0xFE terminator
      5'd3, 5'd4, 5'd4, 5'd6,                            // Reset cycle
      5'd3, 5'd4, 5'd4, 5'd4,                            // Release RS
      5'd7, 5'd4, 5'd4, 5'd4,                            // Read config
      5'd3, 5'd4, 5'd8, 5'd4,                            // Four CSR setups
      5'd7, 5'd4, 5'd4, 5'd4,                            // Read config again
      5'd14, 5'd4, 5'd4, 5'd4, 5'd4, 5'd4, 5'd4,         // Read CSRs
      5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd11,           // CSR write
      5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd11,
      5'd4, 5'd4, 5'd4, 5'd4,                            // Padding
      5'd15, 5'd4, 5'd4, 5'd4,                           // Offset calibration
      5'd16, 5'd4, 5'd4, 5'd4,
      5'd17, 5'd4, 5'd4, 5'd4,
      5'd18, 5'd4, 5'd4, 5'd4
   };

   // Last byte of each frame, bit index is script index
   // Listed from the last frame down to the first
   localparam logic [SCRIPT_LEN-1:0] SCRIPT_LAST = {
      4'b1000, 4'b1000, 4'b1000, 4'b1000,                // Calibrations
      16'h8000,                                          // CSR write
      7'b100_0000,                                       // Read CSRs
      4'b1000, 4'b1000, 4'b1000, 4'b1000, 4'b1000,       // Read back to reset
      16'h8000                                           // Sync
   };

   // Bytes whose MISO data is kept, same bit order as above
   localparam logic [SCRIPT_LEN-1:0] SCRIPT_READ = {
      16'h0000,                                          // Calibrations
      16'h0000,                                          // CSR write
      7'b111_1110,                                       // Two CSR words
      4'b1110, 4'b0000, 4'b1110, 4'b0000, 4'b0000,       // Config read twice
      16'h0000
   };

endpackage

/* verilog/spi_timing_pkg.sv */
package spi_timing_pkg;

   // Counter for sclk half periods and the chip select gap
   typedef logic [2:0] half_cnt_t;

   // clk cycles per sclk half period
   localparam int SCLK_HALF = 4;   // sclk is clk / 8

   // cs_n stays high this long after a frame
   localparam int CS_GAP = 8;

   // Both counts fit in half_cnt_t
   // One byte takes 16 half periods

endpackage

/* verilog/adc_byte_if.sv */
`timescale 1ns/1ns

// One SPI byte transfer between sequencer and byte engine
interface adc_byte_if;

   adc_cmd_pkg::init_byte_t tx_byte;   // Byte to shift out
   logic                    tx_start;  // One cycle launch pulse
   logic                    tx_last;   // Closes the frame after this byte

   adc_cmd_pkg::init_byte_t rx_byte;   // Byte shifted in from miso
   logic                    byte_done; // One cycle, byte finished

   // Sequencer side
   modport master (
      output tx_byte, tx_start, tx_last,
      input  rx_byte, byte_done
   );

   // Byte engine side
   modport slave (
      input  tx_byte, tx_start, tx_last,
      output rx_byte, byte_done
   );

endinterface

/* verilog/initialize_bus_control.sv */
`timescale 1ns/1ns

// Byte table for the CS5523 power-up script
module initialize_bus_control (
   input  adc_cmd_pkg::rom_addr_t  addr,      // Script table address
   output adc_cmd_pkg::init_byte_t data_init  // Byte sent for that address
);

   always_comb
   begin
      case (addr)
         5'h01   : data_init = 8'hFF;   // Port sync fill
         5'h02   : data_init = 8'hFE;   // Sync terminator
         5'h03   : data_init = 8'h03;   // Write config register
         5'h04   : data_init = 8'h00;   // Zero data or read fill
         5'h06   : data_init = 8'h80;   // RS set, starts reset cycle
         5'h07   : data_init = 8'h0B;   // Read config register
         5'h08   : data_init = 8'h30;   // Four CSR setups
         5'h09   : data_init = 8'h05;   // Write CSRs
         5'h0A   : data_init = 8'hB0;   // CSR data
         5'h0B   : data_init = 8'h8B;   // 2.5 V range, unipolar
         5'h0C   : data_init = 8'h10;
         5'h0D   : data_init = 8'hB1;
         5'h0E   : data_init = 8'h0D;   // Read CSRs
         5'h0F   : data_init = 8'h81;   // Offset calibration
         5'h10   : data_init = 8'h82;   // Gain calibration
         5'h11   : data_init = 8'h85;
         5'h12   : data_init = 8'h86;
         default : data_init = 8'h00;   // Address 0, 5 and above 0x12
      endcase
   end

endmodule

/* verilog/adc_init_sequencer.sv */
`timescale 1ns/1ns

// Walks the init script one byte at a time and packs read-back words
module adc_init_sequencer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    start,      // Launches the script
   output logic                    busy,       // High for the whole run
   output logic                    done,       // One cycle at the end
   output adc_cmd_pkg::rom_addr_t  addr,       // Table address
   input  adc_cmd_pkg::init_byte_t data_init,  // Table byte, same cycle
   output adc_cmd_pkg::rd_word_t   rd_word,    // Read-back word
   output logic                    rd_valid,   // rd_word strobe
   adc_byte_if.master              bus
);

   typedef enum logic [1:0]
   {
      S_IDLE,
      S_SEND,
      S_WAIT,
      S_FINISH
   } seq_state_t;

   seq_state_t state;
   logic [6:0] idx;        // Script position
   logic [1:0] rd_cnt;     // Captured bytes in the current word
   logic       rd_frame;   // Frame opened with a read command
   logic       is_rd_cmd;
   logic       capture;

   // Table lookup for the current byte
   assign addr = adc_cmd_pkg::SCRIPT_ADDR[idx];

   assign bus.tx_byte  = data_init;
   assign bus.tx_start = (state == S_SEND);   // Single cycle, state leaves SEND at once
   assign bus.tx_last  = adc_cmd_pkg::SCRIPT_LAST[idx];

   assign is_rd_cmd = (data_init == adc_cmd_pkg::CMD_READ_CFG) ||
                      (data_init == adc_cmd_pkg::CMD_READ_CSR);

   // Keep the MISO byte only in read frames, after the command
   assign capture = (state == S_WAIT) && bus.byte_done && rd_frame &&
                    adc_cmd_pkg::SCRIPT_READ[idx];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= S_IDLE;
         idx      <= '0;
         busy     <= 1'b0;
         done     <= 1'b0;
         rd_valid <= 1'b0;
         rd_cnt   <= '0;
         rd_frame <= 1'b0;
      end
      else
      begin
         // Strobes default low
         done     <= 1'b0;
         rd_valid <= 1'b0;

         case (state)
            S_IDLE:
            begin
               if (start)
               begin
                  busy     <= 1'b1;
                  idx      <= '0;           // Always from the first byte
                  rd_cnt   <= '0;
                  rd_frame <= 1'b0;
                  state    <= S_SEND;
               end
            end

            S_SEND:
            begin
               if (is_rd_cmd)
                  rd_frame <= 1'b1;         // Bytes after this one come back
               state <= S_WAIT;
            end

            S_WAIT:
            begin
               if (bus.byte_done)
               begin
                  // Word complete on the third byte
                  if (capture)
                  begin
                     if (rd_cnt == 2'd2)
                     begin
                        rd_cnt   <= '0;
                        rd_valid <= 1'b1;
                     end
                     else
                        rd_cnt <= rd_cnt + 2'd1;
                  end

                  if (bus.tx_last)
                     rd_frame <= 1'b0;      // Frame closed by the engine

                  if (idx == 7'(adc_cmd_pkg::SCRIPT_LEN - 1))
                     state <= S_FINISH;
                  else
                  begin
                     idx   <= idx + 7'd1;
                     state <= S_SEND;      // tx_start in the cycle after byte_done
                  end
               end
            end

            S_FINISH:
            begin
               done  <= 1'b1;
               busy  <= 1'b0;               // Falls together with done
               state <= S_IDLE;
            end

            default:
               state <= S_IDLE;
         endcase
      end
   end

   // First byte ends up in the high bits
   always_ff @(posedge clk)
   begin
      if (capture)
         rd_word <= {rd_word[15:0], bus.rx_byte};
   end

endmodule

/* verilog/spi_byte_engine.sv */
`timescale 1ns/1ns

// SPI mode 0 byte shifter with chip select framing
module spi_byte_engine (
   input  logic     clk,
   input  logic     rst_n,
   output logic     sclk,    // Idles low
   output logic     cs_n,    // Low across a frame
   output logic     mosi,
   input  logic     miso,
   adc_byte_if.slave bus
);

   typedef enum logic [1:0]
   {
      E_IDLE,
      E_SHIFT,
      E_GAP
   } eng_state_t;

   eng_state_t                state;
   spi_timing_pkg::half_cnt_t half_cnt;   // clk cycles in this half period
   spi_timing_pkg::half_cnt_t gap_cnt;    // cs_n high time after a frame
   logic [3:0]                edge_cnt;   // sclk edges in this byte
   logic                      last_q;     // Byte closes the frame
   adc_cmd_pkg::init_byte_t   tx_shift;
   adc_cmd_pkg::init_byte_t   rx_shift;
   logic                      half_end;
   logic                      gap_end;

   assign half_end = (half_cnt == spi_timing_pkg::half_cnt_t'(spi_timing_pkg::SCLK_HALF - 1));
   assign gap_end  = (gap_cnt == spi_timing_pkg::half_cnt_t'(spi_timing_pkg::CS_GAP - 1));

   assign mosi        = tx_shift[7];   // MSB first
   assign bus.rx_byte = rx_shift;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state         <= E_IDLE;
         sclk          <= 1'b0;
         cs_n          <= 1'b1;
         half_cnt      <= '0;
         gap_cnt       <= '0;
         edge_cnt      <= '0;
         last_q        <= 1'b0;
         tx_shift      <= '0;
         bus.byte_done <= 1'b0;
      end
      else
      begin
         bus.byte_done <= 1'b0;

         case (state)
            E_IDLE:
            begin
               if (bus.tx_start)
               begin
                  tx_shift <= bus.tx_byte;   // First bit on mosi before any edge
                  last_q   <= bus.tx_last;
                  cs_n     <= 1'b0;          // No change inside a frame
                  half_cnt <= '0;
                  edge_cnt <= '0;
                  state    <= E_SHIFT;
               end
            end

            E_SHIFT:
            begin
               if (half_end)
               begin
                  half_cnt <= '0;
                  sclk     <= ~sclk;
                  edge_cnt <= edge_cnt + 4'd1;

                  // Falling edge moves the next bit out
                  if (sclk)
                     tx_shift <= {tx_shift[6:0], 1'b0};

                  // Sixteenth edge leaves sclk low
                  if (edge_cnt == 4'd15)
                  begin
                     if (last_q)
                     begin
                        cs_n    <= 1'b1;
                        gap_cnt <= '0;
                        state   <= E_GAP;
                     end
                     else
                     begin
                        bus.byte_done <= 1'b1;
                        state         <= E_IDLE;
                     end
                  end
               end
               else
                  half_cnt <= half_cnt + 3'd1;
            end

            E_GAP:
            begin
               // byte_done held back until the gap has run out
               if (gap_end)
               begin
                  bus.byte_done <= 1'b1;
                  state         <= E_IDLE;
               end
               else
                  gap_cnt <= gap_cnt + 3'd1;
            end

            default:
               state <= E_IDLE;
         endcase
      end
   end

   // miso sampled on rising sclk
   always_ff @(posedge clk)
   begin
      if ((state == E_SHIFT) && half_end && !sclk)
         rx_shift <= {rx_shift[6:0], miso};
   end

endmodule

/* verilog/adc_init_top.sv */
`timescale 1ns/1ns

// CS5523 init controller, table plus sequencer plus SPI engine
module adc_init_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,      // Run the init script
   input  logic                  miso,
   output logic                  busy,
   output logic                  done,
   output logic                  sclk,
   output logic                  cs_n,
   output logic                  mosi,
   output adc_cmd_pkg::rd_word_t rd_word,    // Config or CSR read-back
   output logic                  rd_valid
);

   adc_cmd_pkg::rom_addr_t  addr;       // Sequencer to table
   adc_cmd_pkg::init_byte_t data_init;  // Table to sequencer

   // Byte handshake between sequencer and engine
   adc_byte_if byte_bus ();

   initialize_bus_control i_table (
      .addr      (addr),
      .data_init (data_init)
   );

   adc_init_sequencer i_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .busy      (busy),
      .done      (done),
      .addr      (addr),
      .data_init (data_init),
      .rd_word   (rd_word),
      .rd_valid  (rd_valid),
      .bus       (byte_bus.master)
   );

   spi_byte_engine i_engine (
      .clk   (clk),
      .rst_n (rst_n),
      .sclk  (sclk),
      .cs_n  (cs_n),
      .mosi  (mosi),
      .miso  (miso),
      .bus   (byte_bus.slave)
   );

endmodule

/* verif/adc_init_chk.sv */
`timescale 1ns/1ns

// SPI framing rules seen at the byte engine
module adc_init_chk (
   input logic clk,
   input logic rst_n,
   input logic sclk,
   input logic cs_n,
   input logic mosi,
   input logic byte_done,   // Engine side of the byte handshake
   input logic tx_start
);

   int fail_cnt = 0;   // Count of failed assertions

   // No clock pulses outside a frame
   sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
      else
      begin
         $error("sclk high while cs_n is high");
         fail_cnt++;
      end

   // Mode 0, data only moves while sclk is low
   mosi_hold: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> $stable(mosi))
      else
      begin
         $error("mosi changed while sclk was high");
         fail_cnt++;
      end

   // Next byte starts only after the done cycle
   no_overlap: assert property (@(posedge clk) disable iff (!rst_n) !(byte_done && tx_start))
      else
      begin
         $error("byte_done and tx_start in the same cycle");
         fail_cnt++;
      end

endmodule

bind spi_byte_engine adc_init_chk i_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .sclk      (sclk),
   .cs_n      (cs_n),
   .mosi      (mosi),
   .byte_done (bus.byte_done),
   .tx_start  (bus.tx_start)
);

/* verif/tb_adc_init.sv */
`timescale 1ns/1ns

module tb_adc_init;

   localparam int CLK_PERIOD = 20;
   localparam int NUM_FRAMES = 12;
   localparam int FRAME_LEN [NUM_FRAMES] = '{16, 4, 4, 4, 4, 4, 7, 16, 4, 4, 4, 4};
   // Shift time plus handshake per byte, gap per frame
   localparam int RUN_CYCLES = adc_cmd_pkg::SCRIPT_LEN * (16 * spi_timing_pkg::SCLK_HALF + 4) +
                               NUM_FRAMES * (spi_timing_pkg::CS_GAP + 2);

   logic        clk;
   logic        rst_n;
   logic        start;
   logic        miso;
   logic        busy;
   logic        done;
   logic        sclk;
   logic        cs_n;
   logic        mosi;
   logic [23:0] rd_word;
   logic        rd_valid;
   logic [23:0] exp_words [$];   // Words the ADC model has sent

   adc_init_top i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .miso     (miso),
      .busy     (busy),
      .done     (done),
      .sclk     (sclk),
      .cs_n     (cs_n),
      .mosi     (mosi),
      .rd_word  (rd_word),
      .rd_valid (rd_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Byte values of the CS5523 init table
   function automatic logic [7:0] table_byte(input logic [4:0] a);
      case (a)
         5'd1    : return 8'hFF;
         5'd2    : return 8'hFE;
         5'd3    : return 8'h03;
         5'd6    : return 8'h80;
         5'd7    : return 8'h0B;   // Read config
         5'd8    : return 8'h30;
         5'd9    : return 8'h05;
         5'd10   : return 8'hB0;
         5'd11   : return 8'h8B;
         5'd12   : return 8'h10;
         5'd13   : return 8'hB1;
         5'd14   : return 8'h0D;   // Read CSRs
         5'd15   : return 8'h81;
         5'd16   : return 8'h82;
         5'd17   : return 8'h85;
         5'd18   : return 8'h86;
         default : return 8'h00;   // Includes the zero fill at 4
      endcase
   endfunction

   task automatic stop_on_failure(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      if (got !== want)
      begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
         stop_on_failure("value mismatch");
      end
   endtask

   task automatic check_idle();
      compare_value("cs_n", cs_n, 1'b1);
      compare_value("sclk", sclk, 1'b0);
      compare_value("mosi", mosi, 1'b0);
      compare_value("busy", busy, 1'b0);
      compare_value("done", done, 1'b0);
      compare_value("rd_valid", rd_valid, 1'b0);
   endtask

   // ADC side, checks mosi and cs_n per byte and answers read frames
   task automatic serve_script();
      int          pos;
      int          n_capt;
      logic        rd_frame;
      logic        capt;
      logic [7:0]  tx;
      logic [7:0]  rx;
      logic [7:0]  want;
      logic [23:0] word;
      pos    = 0;
      n_capt = 0;
      word   = '0;
      rd_frame = 1'b0;
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         for (int k = 0; k < FRAME_LEN[f]; k++)
         begin
            want = table_byte(adc_cmd_pkg::SCRIPT_ADDR[pos]);
            if (k == 0)
               rd_frame = (want == 8'h0B) || (want == 8'h0D);
            capt = rd_frame && (k > 0);         // Everything after the command
            tx   = capt ? 8'($urandom) : 8'h00;
            @(posedge clk);
            miso <= tx[7];                      // MSB ready before the first rise
            for (int b = 7; b >= 0; b--)
            begin
               @(posedge sclk);
               rx[b] = mosi;
               compare_value("cs_n in byte", cs_n, 1'b0);
               @(negedge sclk);
               if (b > 0)
                  miso <= tx[b-1];
            end
            @(negedge clk);
            compare_value("mosi byte", rx, want);
            compare_value("cs_n after byte", cs_n, k == FRAME_LEN[f] - 1);
            if (capt)
            begin
               word = {word[15:0], tx};         // First byte ends high
               n_capt++;
               if (n_capt == 3)
               begin
                  exp_words.push_back(word);
                  n_capt = 0;
               end
            end
            pos++;
         end
      end
   endtask

   // rd_valid strobes up to done
   task automatic collect_words(output int n_words);
      n_words = 0;
      do
      begin
         @(negedge clk);
         if (rd_valid)
         begin
            if (exp_words.size() == 0)
               stop_on_failure("rd_valid pulsed with no word sent by the ADC model");
            else
            begin
               compare_value("rd_word", rd_word, exp_words.pop_front());
               n_words++;
            end
         end
         if (!done)
            compare_value("busy", busy, 1'b1);
      end
      while (!done);
      compare_value("busy at done", busy, 1'b0);   // Falls with done
   endtask

   task automatic run_script(input bit extra_start);
      int n_words;
      compare_value("busy before start", busy, 1'b0);
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      compare_value("busy after start", busy, 1'b1);
      fork
         serve_script();
         collect_words(n_words);
         if (extra_start)
         begin
            repeat (RUN_CYCLES / 2) @(posedge clk);
            start <= 1'b1;                      // Must be ignored while busy
            @(posedge clk);
            start <= 1'b0;
         end
      join
      compare_value("rd_valid count", n_words, 4);
      compare_value("words left", exp_words.size(), 0);
      @(negedge clk);
      compare_value("done width", done, 1'b0);
   endtask

   initial
   begin
      void'($urandom(32'h5a079dbc));
      rst_n <= 1'b0;
      start <= 1'b0;
      miso  <= 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_idle();
      run_script(1'b1);    // Stray start mid-run
      run_script(1'b0);    // Same stream, fresh read data
      // Abort a run with reset, then replay from the first byte
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      repeat (RUN_CYCLES / 3) @(posedge clk);
      rst_n <= 1'b0;
      @(negedge clk);
      check_idle();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      run_script(1'b0);
      $display("all tests passed");
      $finish;
   end

   // Bound SPI protocol checker
   initial
   begin
      wait (i_dut.i_engine.i_chk.fail_cnt != 0);
      stop_on_failure("SPI protocol assertion failed in the byte engine");
   end

   // Three full runs, one aborted run and slack
   initial
   begin
      repeat (5 * RUN_CYCLES) @(posedge clk);
      stop_on_failure("Watchdog expired before the tests finished");
   end

endmodule

/* sources.f */
verilog/adc_cmd_pkg.sv
verilog/spi_timing_pkg.sv
verilog/adc_byte_if.sv
verilog/initialize_bus_control.sv
verilog/adc_init_sequencer.sv
verilog/spi_byte_engine.sv
verilog/adc_init_top.sv
verif/adc_init_chk.sv
verif/tb_adc_init.sv

/* Bender.yml */
package:
  name: adc_init

sources:
  - verilog/adc_cmd_pkg.sv
  - verilog/spi_timing_pkg.sv
  - verilog/adc_byte_if.sv
  - verilog/initialize_bus_control.sv
  - verilog/adc_init_sequencer.sv
  - verilog/spi_byte_engine.sv
  - verilog/adc_init_top.sv
  - target: test
    files:
      - verif/adc_init_chk.sv
      - verif/tb_adc_init.sv
